// ==== all.f ====
verilog/fog_pkg.sv
verilog/fog_modulator.sv
verilog/fog_demodulator.sv
verilog/fog_step_integrator.sv
verilog/fog_phase_ramp.sv
verilog/fog_loop_top.sv
tb/tb_clock_gen.sv
tb/tb_fog_loop.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_fog_loop -f all.f -o tb_fog_loop \
	> build.log 2>&1 \
	&& ./obj_dir/tb_fog_loop > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== tb/tb_fog_loop.sv ====
module tb_fog_loop;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADC_WIDTH = fog_pkg::ADC_WIDTH_DEFAULT;
	// longest any single wait may take in cycles
	localparam int WAIT_LIMIT = 1000;
	// room for settle + 64 samples + input registers
	localparam fog_pkg::count_t HALF_NOMINAL   = 32'd80;
	localparam fog_pkg::count_t SETTLE_NOMINAL = 32'd3;

	logic                CLOCK_DAC_1;
	logic                i_rst_n;
	// plant output is 0 until the first edge
	logic signed [ADC_WIDTH-1:0] i_adc = '0;
	fog_pkg::count_t     i_half_cnt;
	fog_pkg::ctrl_word_t i_amp_h;
	fog_pkg::ctrl_word_t i_amp_l;
	fog_pkg::count_t     i_wait_cnt;
	fog_pkg::avg_sel_t   i_avg_sel;
	logic                i_polarity;
	fog_pkg::ctrl_word_t i_err_offset;
	logic                i_fb_on;
	fog_pkg::ctrl_word_t i_const_step;
	fog_pkg::gain_sel_t  i_step_gain;
	fog_pkg::gain_sel_t  i_ramp_gain;
	fog_pkg::dac_word_t  o_dac;
	logic                o_mod_status;
	fog_pkg::ctrl_word_t o_err;
	logic                o_err_valid;
	fog_pkg::ctrl_word_t o_step;
	logic                o_step_valid;

	// detector levels for the high and low halves
	logic signed [ADC_WIDTH-1:0] plant_a;
	logic signed [ADC_WIDTH-1:0] plant_b;

	int          errors;
	int          tests;
	logic        aborted;
	logic [31:0] rng_state;

	// ramp model and the DAC word expected one cycle on
	fog_pkg::ctrl_word_t model_ramp;
	fog_pkg::dac_word_t  dac_expect;
	logic                dac_check_on;

	tb_clock_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (3)
	) tb_clock_gen_i (
		.o_clk   (CLOCK_DAC_1),
		.o_rst_n (i_rst_n)
	);

	fog_loop_top #(
		.ADC_WIDTH (ADC_WIDTH)
	) fog_loop_top_i (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_adc        (i_adc),
		.i_half_cnt   (i_half_cnt),
		.i_amp_h      (i_amp_h),
		.i_amp_l      (i_amp_l),
		.i_wait_cnt   (i_wait_cnt),
		.i_avg_sel    (i_avg_sel),
		.i_polarity   (i_polarity),
		.i_err_offset (i_err_offset),
		.i_fb_on      (i_fb_on),
		.i_const_step (i_const_step),
		.i_step_gain  (i_step_gain),
		.i_ramp_gain  (i_ramp_gain),
		.o_dac        (o_dac),
		.o_mod_status (o_mod_status),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid),
		.o_step       (o_step),
		.o_step_valid (o_step_valid)
	);

	// plant model follows the modulation half one cycle late
	always @(posedge CLOCK_DAC_1) begin
		i_adc <= o_mod_status ? plant_a : plant_b;
	end

	// xorshift32 with shifts 13 17 5
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_random(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	// polarity-signed difference of the levels plus offset with 32-bit wrap
	function automatic fog_pkg::ctrl_word_t expected_error(
		input logic signed [ADC_WIDTH-1:0] a,
		input logic signed [ADC_WIDTH-1:0] b,
		input logic                        pol,
		input fog_pkg::ctrl_word_t         off
	);
		fog_pkg::ctrl_word_t a_w;
		fog_pkg::ctrl_word_t b_w;
		a_w = a;
		b_w = b;
		if (pol) begin
			return b_w - a_w + off;
		end else begin
			return a_w - b_w + off;
		end
	endfunction

	task automatic report_mismatch(input string name, input longint expected,
		input longint actual);
		errors++;
		$display("mismatch at %0d ns: %s expected %0d got %0d", $time, name, expected, actual);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		aborted = 1'b1;
		$display("timeout at %0d ns: %s within %0d cycles", $time, what, WAIT_LIMIT);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests++;
		$display("%s finished at %0d ns with %0d errors", name, $time, errors - start_errors);
	endtask

	// every sample point is a falling edge
	// the ramp model steps here so no cycle is missed
	task automatic next_sample();
		fog_pkg::ctrl_word_t cur_mod;
		fog_pkg::ctrl_word_t step_scaled;
		@(negedge CLOCK_DAC_1);
		if (!i_rst_n) begin
			model_ramp = '0;
			dac_expect = '0;
		end else begin
			if (dac_check_on && o_dac !== dac_expect) begin
				report_mismatch("o_dac", dac_expect, o_dac);
			end
			// amplitude of this cycle lands in o_dac next cycle
			cur_mod    = o_mod_status ? i_amp_h : i_amp_l;
			dac_expect = model_ramp[31:16] + cur_mod[15:0];
			// ramp picks the step up on the coming edge
			if (o_step_valid) begin
				step_scaled = o_step >>> i_ramp_gain;
				model_ramp  = model_ramp + step_scaled;
			end
		end
	endtask

	task automatic wait_err_valid();
		int n;
		n = 0;
		next_sample();
		while (o_err_valid !== 1'b1 && n < WAIT_LIMIT) begin
			next_sample();
			n++;
		end
		if (o_err_valid !== 1'b1) begin
			report_timeout("o_err_valid never pulsed");
		end
	endtask

	// throw away results that may mix old and new settings
	task automatic skip_valids(input int count);
		int k;
		for (k = 0; k < count && !aborted; k++) begin
			wait_err_valid();
		end
	endtask

	// samples until o_mod_status leaves its present level
	task automatic wait_status_change(output int len);
		logic start_level;
		start_level = o_mod_status;
		next_sample();
		len = 1;
		while (o_mod_status === start_level && len < WAIT_LIMIT) begin
			next_sample();
			len++;
		end
		if (o_mod_status === start_level) begin
			report_timeout("o_mod_status never toggled");
		end
	endtask

	task automatic apply_error_setup(
		input logic signed [ADC_WIDTH-1:0] a,
		input logic signed [ADC_WIDTH-1:0] b,
		input logic                        pol,
		input fog_pkg::ctrl_word_t         off,
		input fog_pkg::avg_sel_t           sel,
		input fog_pkg::count_t             settle
	);
		@(posedge CLOCK_DAC_1);
		plant_a      <= a;
		plant_b      <= b;
		i_polarity   <= pol;
		i_err_offset <= off;
		i_avg_sel    <= sel;
		i_wait_cnt   <= settle;
		i_half_cnt   <= HALF_NOMINAL;
	endtask

	task automatic test_reset_state();
		int start_err;
		int n;
		start_err = errors;
		n = 0;
		next_sample();
		while (!i_rst_n && n < WAIT_LIMIT) begin
			next_sample();
			n++;
		end
		if (!i_rst_n) begin
			report_timeout("reset was never released");
		end
		// no period has completed yet so everything is idle
		// high half comes first out of reset
		repeat (20) begin
			next_sample();
			if (o_err_valid !== 1'b0) report_mismatch("o_err_valid", 0, o_err_valid);
			if (o_step_valid !== 1'b0) report_mismatch("o_step_valid", 0, o_step_valid);
			if (o_err !== '0) report_mismatch("o_err", 0, o_err);
			if (o_step !== '0) report_mismatch("o_step", 0, o_step);
			if (o_dac !== '0) report_mismatch("o_dac", 0, o_dac);
			if (o_mod_status !== 1'b1) report_mismatch("o_mod_status", 1, o_mod_status);
		end
		finish_test("reset state", start_err);
	endtask

	task automatic test_modulation();
		int start_err;
		int k;
		int len;
		logic [31:0] r;
		fog_pkg::count_t half;
		start_err = errors;
		draw_random(r);
		half = 32'd20 + (r % 32'd20);
		@(posedge CLOCK_DAC_1);
		i_fb_on      <= 1'b0;
		i_const_step <= '0;
		i_half_cnt   <= half;
		draw_random(r);
		i_amp_h      <= r;
		draw_random(r);
		i_amp_l      <= r;
		// ramp stays at 0 so o_dac is the amplitude alone
		dac_check_on = 1'b1;
		next_sample();
		// new period starts at the next boundary
		wait_status_change(len);
		for (k = 0; k < 4 && !aborted; k++) begin
			wait_status_change(len);
			if (!aborted && len != half) begin
				report_mismatch("o_mod_status half length", half, len);
			end
		end
		dac_check_on = 1'b0;
		finish_test("modulation", start_err);
	endtask

	task automatic test_error_value();
		int start_err;
		int cfg;
		int k;
		logic [31:0] r;
		logic signed [ADC_WIDTH-1:0] a;
		logic signed [ADC_WIDTH-1:0] b;
		fog_pkg::ctrl_word_t off;
		fog_pkg::ctrl_word_t expected;
		start_err = errors;
		for (cfg = 0; cfg < 4 && !aborted; cfg++) begin
			draw_random(r);
			a = r[13:0];
			b = r[29:16];
			draw_random(r);
			off = (cfg == 0) ? '0 : r;
			// windows of 1 4 16 and 64 samples with alternating polarity
			apply_error_setup(a, b, cfg[0], off, fog_pkg::avg_sel_t'(cfg * 2),
				SETTLE_NOMINAL + 32'(cfg));
			skip_valids(2);
			expected = expected_error(a, b, cfg[0], off);
			for (k = 0; k < 2 && !aborted; k++) begin
				wait_err_valid();
				if (!aborted && o_err !== expected) begin
					report_mismatch("o_err", expected, o_err);
				end
			end
		end
		finish_test("error value", start_err);
	endtask

	task automatic test_const_step();
		int start_err;
		int k;
		logic [31:0] r;
		fog_pkg::ctrl_word_t step_exp;
		start_err = errors;
		draw_random(r);
		step_exp = r;
		@(posedge CLOCK_DAC_1);
		i_fb_on      <= 1'b0;
		i_const_step <= step_exp;
		for (k = 0; k < 3 && !aborted; k++) begin
			wait_err_valid();
			if (!aborted) begin
				if (o_step_valid !== 1'b0) report_mismatch("o_step_valid", 0, o_step_valid);
				next_sample();
				if (o_step_valid !== 1'b1) report_mismatch("o_step_valid", 1, o_step_valid);
				if (o_step !== step_exp) report_mismatch("o_step", step_exp, o_step);
			end
		end
		finish_test("constant step", start_err);
	endtask

	task automatic test_integrating_feedback();
		int start_err;
		int k;
		logic [31:0] r;
		logic signed [ADC_WIDTH-1:0] a;
		logic signed [ADC_WIDTH-1:0] b;
		logic pol;
		fog_pkg::ctrl_word_t off;
		fog_pkg::gain_sel_t  gain;
		fog_pkg::ctrl_word_t err_exp;
		fog_pkg::ctrl_word_t step_model;
		start_err = errors;
		draw_random(r);
		a   = r[13:0];
		b   = r[29:16];
		pol = r[31];
		draw_random(r);
		off  = {{16{r[15]}}, r[15:0]};
		gain = r[20:16];
		apply_error_setup(a, b, pol, off, 3'd4, SETTLE_NOMINAL);
		i_step_gain <= gain;
		skip_valids(2);
		// still open loop so the step holds the constant
		step_model = i_const_step;
		@(posedge CLOCK_DAC_1);
		i_fb_on <= 1'b1;
		err_exp = expected_error(a, b, pol, off);
		for (k = 0; k < 6 && !aborted; k++) begin
			wait_err_valid();
			if (!aborted) begin
				if (o_err !== err_exp) report_mismatch("o_err", err_exp, o_err);
				next_sample();
				step_model = step_model + (err_exp >>> gain);
				if (o_step_valid !== 1'b1) report_mismatch("o_step_valid", 1, o_step_valid);
				if (o_step !== step_model) report_mismatch("o_step", step_model, o_step);
			end
		end
		finish_test("integrating feedback", start_err);
	endtask

	task automatic test_phase_ramp();
		int start_err;
		logic [31:0] r;
		start_err = errors;
		@(posedge CLOCK_DAC_1);
		// large open-loop step so the ramp top moves and wraps
		i_fb_on      <= 1'b0;
		draw_random(r);
		i_const_step <= r;
		i_ramp_gain  <= {2'b00, r[2:0]};
		draw_random(r);
		i_amp_h      <= r;
		draw_random(r);
		i_amp_l      <= r;
		dac_check_on = 1'b1;
		skip_valids(4);
		next_sample();
		next_sample();
		dac_check_on = 1'b0;
		finish_test("phase ramp", start_err);
	endtask

	initial begin
		errors       = 0;
		tests        = 0;
		aborted      = 1'b0;
		rng_state    = 32'd81010;
		model_ramp   = '0;
		dac_expect   = '0;
		dac_check_on = 1'b0;
		plant_a      = '0;
		plant_b      = '0;
		i_half_cnt   = HALF_NOMINAL;
		i_amp_h      = '0;
		i_amp_l      = '0;
		i_wait_cnt   = SETTLE_NOMINAL;
		i_avg_sel    = '0;
		i_polarity   = 1'b0;
		i_err_offset = '0;
		i_fb_on      = 1'b0;
		i_const_step = '0;
		i_step_gain  = '0;
		i_ramp_gain  = '0;

		test_reset_state();
		if (!aborted) test_modulation();
		if (!aborted) test_error_value();
		if (!aborted) test_const_step();
		if (!aborted) test_integrating_feedback();
		if (!aborted) test_phase_ramp();

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// free-running clock, low at time 0
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset low across the first rising edges, released on an edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

// ==== verilog/fog_loop_top.sv ====
module fog_loop_top #(
	parameter int ADC_WIDTH = fog_pkg::ADC_WIDTH_DEFAULT
) (
	input  logic                        CLOCK_DAC_1,
	input  logic                        i_rst_n,
	input  logic signed [ADC_WIDTH-1:0] i_adc,
	input  fog_pkg::count_t             i_half_cnt,
	input  fog_pkg::ctrl_word_t         i_amp_h,
	input  fog_pkg::ctrl_word_t         i_amp_l,
	input  fog_pkg::count_t             i_wait_cnt,
	input  fog_pkg::avg_sel_t           i_avg_sel,
	input  logic                        i_polarity,
	input  fog_pkg::ctrl_word_t         i_err_offset,
	input  logic                        i_fb_on,
	input  fog_pkg::ctrl_word_t         i_const_step,
	input  fog_pkg::gain_sel_t          i_step_gain,
	input  fog_pkg::gain_sel_t          i_ramp_gain,
	output fog_pkg::dac_word_t          o_dac,
	output logic                        o_mod_status,
	output fog_pkg::ctrl_word_t         o_err,
	output logic                        o_err_valid,
	output fog_pkg::ctrl_word_t         o_step,
	output logic                        o_step_valid
);

	// modulation word into the DAC sum
	fog_pkg::ctrl_word_t mod;

	// first cycle of each half
	logic half_start;

	// square-wave phase modulation
	fog_modulator fog_modulator_i (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_half_cnt   (i_half_cnt),
		.i_amp_h      (i_amp_h),
		.i_amp_l      (i_amp_l),
		.o_mod        (mod),
		.o_mod_status (o_mod_status),
		.o_half_start (half_start)
	);

	// high minus low average per period
	fog_demodulator #(
		.ADC_WIDTH (ADC_WIDTH)
	) fog_demodulator_i (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_adc        (i_adc),
		.i_mod_status (o_mod_status),
		.i_half_start (half_start),
		.i_wait_cnt   (i_wait_cnt),
		.i_avg_sel    (i_avg_sel),
		.i_polarity   (i_polarity),
		.i_err_offset (i_err_offset),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid)
	);

	// feedback step, constant or integrated
	fog_step_integrator fog_step_integrator_i (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_err        (o_err),
		.i_err_valid  (o_err_valid),
		.i_fb_on      (i_fb_on),
		.i_const_step (i_const_step),
		.i_step_gain  (i_step_gain),
		.o_step       (o_step),
		.o_step_valid (o_step_valid)
	);

	// ramp plus modulation to the DAC
	fog_phase_ramp fog_phase_ramp_i (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_step       (o_step),
		.i_step_valid (o_step_valid),
		.i_ramp_gain  (i_ramp_gain),
		.i_mod        (mod),
		.o_dac        (o_dac)
	);

endmodule

// ==== verilog/fog_phase_ramp.sv ====
module fog_phase_ramp (
	input  logic                CLOCK_DAC_1,
	input  logic                i_rst_n,
	input  fog_pkg::ctrl_word_t i_step,
	input  logic                i_step_valid,
	input  fog_pkg::gain_sel_t  i_ramp_gain,
	input  fog_pkg::ctrl_word_t i_mod,
	output fog_pkg::dac_word_t  o_dac
);

	localparam int DW = fog_pkg::DAC_WIDTH;
	localparam int CW = fog_pkg::CTRL_WIDTH;

	// phase ramp accumulator
	fog_pkg::ctrl_word_t ramp;

	// step after the ramp gain
	fog_pkg::ctrl_word_t step_scaled;

	// DAC word before the output register
	fog_pkg::dac_word_t dac_next;

	assign step_scaled = i_step >>> i_ramp_gain;

	// top of the ramp plus low half of the modulation
	// sum drops the carry, modulo 2**16
	assign dac_next = ramp[CW-1:CW-DW] + i_mod[DW-1:0];

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			ramp  <= '0;
			o_dac <= '0;
		end else begin
			// one update per step strobe, wraps at 32 bits
			if (i_step_valid) begin
				ramp <= ramp + step_scaled;
			end
			// registered every cycle
			o_dac <= dac_next;
		end
	end

endmodule

// ==== verilog/fog_step_integrator.sv ====
module fog_step_integrator (
	input  logic                CLOCK_DAC_1,
	input  logic                i_rst_n,
	input  fog_pkg::ctrl_word_t i_err,
	input  logic                i_err_valid,
	input  logic                i_fb_on,
	input  fog_pkg::ctrl_word_t i_const_step,
	input  fog_pkg::gain_sel_t  i_step_gain,
	output fog_pkg::ctrl_word_t o_step,
	output logic                o_step_valid
);

	// error after the loop gain
	fog_pkg::ctrl_word_t err_scaled;

	// next step value in feedback mode
	fog_pkg::ctrl_word_t step_sum;

	assign err_scaled = i_err >>> i_step_gain;

	// wraps at 32 bits
	assign step_sum = o_step + err_scaled;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			o_step       <= '0;
			o_step_valid <= 1'b0;
		end else begin
			// valid follows the error strobe by one cycle
			o_step_valid <= i_err_valid;
			if (i_err_valid) begin
				if (i_fb_on) begin
					// closed loop, integrate the error
					o_step <= step_sum;
				end else begin
					// open loop, fixed step
					o_step <= i_const_step;
				end
			end
		end
	end

endmodule

// ==== verilog/fog_demodulator.sv ====
module fog_demodulator #(
	parameter int ADC_WIDTH = fog_pkg::ADC_WIDTH_DEFAULT
) (
	input  logic                        CLOCK_DAC_1,
	input  logic                        i_rst_n,
	input  logic signed [ADC_WIDTH-1:0] i_adc,
	input  logic                        i_mod_status,
	input  logic                        i_half_start,
	input  fog_pkg::count_t             i_wait_cnt,
	input  fog_pkg::avg_sel_t           i_avg_sel,
	input  logic                        i_polarity,
	input  fog_pkg::ctrl_word_t         i_err_offset,
	output fog_pkg::ctrl_word_t         o_err,
	output logic                        o_err_valid
);

	// room for the largest window without overflow
	localparam int SUM_W = ADC_WIDTH + fog_pkg::AVG_SEL_MAX;
	localparam int WIN_W = fog_pkg::AVG_SEL_MAX + 1;

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_SUM,
		ST_DONE
	} state_t;

	state_t state;

	// two-stage ADC input
	logic signed [ADC_WIDTH-1:0] adc_d1;
	logic signed [ADC_WIDTH-1:0] adc_d2;

	// settle and window counters
	fog_pkg::count_t   wait_cnt;
	logic [WIN_W-1:0]  win_cnt;
	logic [WIN_W-1:0]  win_len;

	// per-half settings, frozen at the half start
	logic              half_high;
	fog_pkg::avg_sel_t avg_sel_q;
	fog_pkg::avg_sel_t sel_eff;

	// set once a full high window has been averaged
	logic have_high;

	logic signed [SUM_W-1:0] sample_ext;
	logic signed [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] sum_next;

	fog_pkg::ctrl_word_t avg_cur;
	fog_pkg::ctrl_word_t avg_h;
	fog_pkg::ctrl_word_t err_next;

	// exponents above the limit would overflow the sum
	assign sel_eff = (i_avg_sel > fog_pkg::AVG_SEL_MAX) ?
		fog_pkg::avg_sel_t'(fog_pkg::AVG_SEL_MAX) : i_avg_sel;

	assign win_len = WIN_W'(1) << avg_sel_q;

	// sign extend sample to the accumulator
	assign sample_ext = adc_d2;
	assign sum_next   = sum + sample_ext;

	// average including the sample of this cycle
	assign avg_cur = sum_next >>> avg_sel_q;

	// error from the high average and the low one just finished
	assign err_next = i_polarity ? (avg_cur - avg_h + i_err_offset) :
		(avg_h - avg_cur + i_err_offset);

	// sample arrives here 2 cycles late
	always_ff @(posedge CLOCK_DAC_1) begin
		adc_d1 <= i_adc;
		adc_d2 <= adc_d1;
	end

	// half state machine
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			state       <= ST_DONE;
			wait_cnt    <= '0;
			win_cnt     <= '0;
			half_high   <= 1'b0;
			avg_sel_q   <= '0;
			have_high   <= 1'b0;
			o_err       <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= 1'b0;
			if (i_half_start) begin
				// restart for the new half
				state     <= ST_WAIT;
				wait_cnt  <= i_wait_cnt;
				half_high <= i_mod_status;
				avg_sel_q <= sel_eff;
				if (i_mod_status) begin
					have_high <= 1'b0;
				end
			end else begin
				case (state)
					ST_WAIT: begin
						if (wait_cnt == '0) begin
							state   <= ST_SUM;
							win_cnt <= win_len - 1'b1;
						end else begin
							wait_cnt <= wait_cnt - 32'd1;
						end
					end
					ST_SUM: begin
						if (win_cnt == '0) begin
							// window closes on this sample
							state <= ST_DONE;
							if (half_high) begin
								have_high <= 1'b1;
							end else if (have_high) begin
								o_err       <= err_next;
								o_err_valid <= 1'b1;
							end
						end else begin
							win_cnt <= win_cnt - 1'b1;
						end
					end
					default: begin
						// idle until next half start
						state <= ST_DONE;
					end
				endcase
			end
		end
	end

	// accumulator and stored high average
	always_ff @(posedge CLOCK_DAC_1) begin
		if (state == ST_WAIT && wait_cnt == '0) begin
			sum <= '0;
		end else if (state == ST_SUM) begin
			sum <= sum_next;
		end
		if (state == ST_SUM && win_cnt == '0 && half_high) begin
			avg_h <= avg_cur;
		end
	end

endmodule

// ==== verilog/fog_modulator.sv ====
module fog_modulator (
	input  logic                CLOCK_DAC_1,
	input  logic                i_rst_n,
	input  fog_pkg::count_t     i_half_cnt,
	input  fog_pkg::ctrl_word_t i_amp_h,
	input  fog_pkg::ctrl_word_t i_amp_l,
	output fog_pkg::ctrl_word_t o_mod,
	output logic                o_mod_status,
	output logic                o_half_start
);

	// cycles left in the current half after the present one
	// don't care in the first cycle of a half, reloaded there
	fog_pkg::count_t half_cnt;

	// 1 while in the high half
	logic status;

	// first cycle of a half
	logic half_start;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			// come out of reset at the start of a high half
			status     <= 1'b1;
			half_start <= 1'b1;
			half_cnt   <= '0;
		end else if (half_start) begin
			// sample the period here so a new value waits for the boundary
			// half_cnt >= 2 is assumed, this cycle and the next are spent
			half_cnt   <= i_half_cnt - 32'd2;
			half_start <= 1'b0;
		end else if (half_cnt == '0) begin
			// last cycle of the half
			status     <= ~status;
			half_start <= 1'b1;
		end else begin
			half_cnt <= half_cnt - 32'd1;
		end
	end

	// amplitude follows the half directly
	assign o_mod = status ? i_amp_h : i_amp_l;

	assign o_mod_status = status;

	// trigger for the demodulator window
	assign o_half_start = half_start;

endmodule

// ==== verilog/fog_pkg.sv ====
package fog_pkg;

	// width of every control word and loop variable
	localparam int CTRL_WIDTH = 32;

	// DAC output word width
	localparam int DAC_WIDTH = 16;

	// default ADC sample width
	localparam int ADC_WIDTH_DEFAULT = 14;

	// largest averaging exponent, so 64 samples at most
	localparam int AVG_SEL_MAX = 6;

	// signed loop word
	// used for amplitudes, error, offset, step and ramp
	typedef logic signed [CTRL_WIDTH-1:0] ctrl_word_t;

	// unsigned DAC code
	typedef logic [DAC_WIDTH-1:0] dac_word_t;

	// cycle counts for half period and settle wait
	typedef logic [CTRL_WIDTH-1:0] count_t;

	// averaging exponent, window is 2**sel samples
	typedef logic [2:0] avg_sel_t;

	// arithmetic right-shift amount for step and ramp gains
	typedef logic [4:0] gain_sel_t;

endpackage
